// File: src/wb_resize_pkg.sv
// Shared widths, word types and lane helper for the 32-to-8 bit Wishbone bridge
package wb_resize_pkg;

  ////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////

  localparam int AW     = 32;             // Address width
  localparam int MDW    = 32;             // Master data width
  localparam int SDW    = 8;              // Slave data width
  localparam int LANES  = MDW / SDW;      // Byte lanes per master word
  localparam int LANE_W = $clog2(LANES);  // Bits to name one lane

  ////////////////////////////////////////////////////////////
  // Word types
  ////////////////////////////////////////////////////////////

  typedef logic [AW-1:0]     adr_t;   // Bus address
  typedef logic [MDW-1:0]    mdat_t;  // Master data word
  typedef logic [SDW-1:0]    sdat_t;  // Slave data byte
  typedef logic [LANES-1:0]  sel_t;   // Master byte select
  typedef logic [LANE_W-1:0] lane_t;  // Lane index, MSB lane is 3

  // Big-endian mapping: lane 3 sits at byte offset 0
  function automatic lane_t lane_offset(lane_t lane);
    lane_t offset;
    offset = lane_t'(LANES - 1 - int'(lane));
    return offset;
  endfunction

endpackage

// File: src/wb_lane_sequencer.sv
// FSM that turns one 32-bit master access into narrow slave cycles, one per selected lane
module wb_lane_sequencer (
  input  logic clk_i,
  input  logic rst_i,
  // Master request
  input  logic wbm_cyc_i,
  input  logic wbm_stb_i,
  // Lane counter status
  input  logic any_i,      // Lanes still pending
  input  logic last_i,     // Current lane is the final one
  // Slave response
  input  logic wbs_ack_i,
  input  logic wbs_err_i,
  // Control to counter and datapath
  output logic start_o,
  output logic advance_o,
  // Slave request
  output logic wbs_cyc_o,
  output logic wbs_stb_o,
  // Master response
  output logic wbm_ack_o,
  output logic wbm_err_o
);

  ////////////////////////////////////////////////////////////
  // State encoding
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,     // Waiting for a master request
    ACCEPT,   // Mask loaded, first narrow cycle may start
    ISSUE,    // Slave stb held until ack or err
    GAP,      // One idle cycle between lanes
    RESPOND   // One-cycle ack or err to master
  } state_e;

  state_e state_q, state_d;
  logic   err_q, err_d;       // Sticky error for this access

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    case (state_q)
      IDLE: begin
        if (wbm_cyc_i && wbm_stb_i) begin
          state_d = ACCEPT;
          err_d   = 1'b0;                 // Fresh access
        end
      end
      ACCEPT: begin
        // Empty select skips the slave entirely
        state_d = any_i ? ISSUE : RESPOND;
      end
      ISSUE: begin
        if (wbs_err_i) begin
          state_d = RESPOND;              // Abort remaining lanes
          err_d   = 1'b1;
        end else if (wbs_ack_i) begin
          state_d = last_i ? RESPOND : GAP;
        end
      end
      GAP:     state_d = ISSUE;           // Counter has moved on by now
      RESPOND: state_d = IDLE;            // Master drops stb after this
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign start_o   = (state_q == IDLE) && wbm_cyc_i && wbm_stb_i;
  assign advance_o = (state_q == ISSUE) && wbs_ack_i;   // One step per slave ack

  // Stb rises in ACCEPT so the first lane starts right after acceptance
  assign wbs_stb_o = (state_q == ISSUE) || ((state_q == ACCEPT) && any_i);
  assign wbs_cyc_o = wbs_stb_o;                         // Single cycles only

  assign wbm_ack_o = (state_q == RESPOND) && !err_q;
  assign wbm_err_o = (state_q == RESPOND) && err_q;

endmodule

// File: src/wb_lane_counter.sv
// Tracks the lanes still to be transferred and names the current and final lane
module wb_lane_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,    // Load select mask
  input  logic                 advance_i,  // Current lane done
  input  wb_resize_pkg::sel_t  sel_i,
  output wb_resize_pkg::lane_t lane_o,     // Highest pending lane
  output logic                 any_o,      // At least one lane left
  output logic                 last_o      // Exactly one lane left
);

  import wb_resize_pkg::*;

  sel_t mask_q;   // Pending lanes, one bit each

  ////////////////////////////////////////////////////////////
  // Mask register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '0;
    end else if (start_i) begin
      mask_q <= sel_i;
    end else if (advance_i) begin
      mask_q[lane_o] <= 1'b0;             // Retire the lane just served
    end
  end

  ////////////////////////////////////////////////////////////
  // Priority encoder, lane 3 first
  ////////////////////////////////////////////////////////////

  always_comb begin
    lane_o = '0;
    for (int i = 0; i < LANES; i++) begin
      if (mask_q[i]) lane_o = lane_t'(i); // Later hit wins, so highest lane
    end
  end

  assign any_o = |mask_q;

  // Clearing the lowest set bit leaves zero only for a single bit
  assign last_o = any_o && ((mask_q & (mask_q - sel_t'(1))) == '0);

endmodule

// File: src/wb_lane_datapath.sv
// Narrow address and write byte per lane, plus assembly of the 32-bit read word
module wb_lane_datapath (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,    // New access, clear read word
  input  logic                 advance_i,  // Slave byte valid for lane_i
  input  wb_resize_pkg::lane_t lane_i,
  // Master side
  input  wb_resize_pkg::adr_t  wbm_adr_i,
  input  wb_resize_pkg::mdat_t wbm_dat_i,
  output wb_resize_pkg::mdat_t wbm_dat_o,
  // Slave side
  input  wb_resize_pkg::sdat_t wbs_dat_i,
  output wb_resize_pkg::adr_t  wbs_adr_o,
  output wb_resize_pkg::sdat_t wbs_dat_o
);

  import wb_resize_pkg::*;

  mdat_t rdata_q;   // Read word under assembly
  lane_t offset;    // Byte offset of current lane

  ////////////////////////////////////////////////////////////
  // Slave address
  ////////////////////////////////////////////////////////////

  // Word part passes through, low bits pick the byte
  assign offset    = lane_offset(lane_i);
  assign wbs_adr_o = {wbm_adr_i[AW-1:LANE_W], offset};

  ////////////////////////////////////////////////////////////
  // Write byte select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (lane_i)
      lane_t'(3): wbs_dat_o = wbm_dat_i[31:24];   // MSB to offset 0
      lane_t'(2): wbs_dat_o = wbm_dat_i[23:16];
      lane_t'(1): wbs_dat_o = wbm_dat_i[15:8];
      default:    wbs_dat_o = wbm_dat_i[7:0];     // LSB to offset 3
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Read word assembly
  ////////////////////////////////////////////////////////////

  // Unselected lanes keep the zero from start_i
  always_ff @(posedge clk_i) begin
    if (rst_i || start_i) begin
      rdata_q <= '0;
    end else if (advance_i) begin
      rdata_q[lane_i*SDW +: SDW] <= wbs_dat_i;    // Drop byte into its lane
    end
  end

  assign wbm_dat_o = rdata_q;   // Stable through the master ack cycle

endmodule

// File: src/wb_byte_ram.sv
// Byte-wide Wishbone slave memory with fixed wait states and an out-of-range error
module wb_byte_ram #(
  parameter int DEPTH       = 64,  // Size in bytes
  parameter int WAIT_CYCLES = 1    // Extra cycles before ack
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  wb_resize_pkg::adr_t  adr_i,
  input  wb_resize_pkg::sdat_t dat_i,
  output wb_resize_pkg::sdat_t dat_o,
  output logic                 ack_o,
  output logic                 err_o
);

  import wb_resize_pkg::*;

  localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;             // Index width
  localparam int CW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  sdat_t         mem [DEPTH];
  logic [CW-1:0] wait_q;       // Cycles of stb seen so far
  logic          req;          // Live request, not yet answered
  logic          done;         // Wait over, respond next edge
  logic          in_range;

  assign req      = cyc_i && stb_i && !ack_o && !err_o;
  assign done     = req && (wait_q == CW'(WAIT_CYCLES));
  assign in_range = adr_i < adr_t'(DEPTH);

  ////////////////////////////////////////////////////////////
  // Wait timer and response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= '0;
      ack_o  <= 1'b0;
      err_o  <= 1'b0;
    end else begin
      ack_o <= done && in_range;        // One-cycle pulses
      err_o <= done && !in_range;
      if (done || !req) begin
        wait_q <= '0;                   // Rearm for the next stb
      end else begin
        wait_q <= wait_q + CW'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Out-of-range access never touches the array
  always_ff @(posedge clk_i) begin
    if (done && in_range) begin
      if (we_i) mem[adr_i[IW-1:0]] <= dat_i;
      dat_o <= we_i ? dat_i : mem[adr_i[IW-1:0]];   // Echo on write
    end
  end

endmodule

// File: src/wb_resize_bridge.sv
// Top level of the 32-bit master to 8-bit slave bridge with its byte RAM behind it
module wb_resize_bridge (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // 32-bit Wishbone master port
  input  wb_resize_pkg::adr_t  wbm_adr_i,
  input  wb_resize_pkg::mdat_t wbm_dat_i,
  input  wb_resize_pkg::sel_t  wbm_sel_i,
  input  logic                 wbm_we_i,
  input  logic                 wbm_cyc_i,
  input  logic                 wbm_stb_i,
  output wb_resize_pkg::mdat_t wbm_dat_o,
  output logic                 wbm_ack_o,
  output logic                 wbm_err_o
);

  import wb_resize_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  // Narrow slave bus
  adr_t  wbs_adr;
  sdat_t wbs_dat;     // Write byte
  sdat_t wbs_dat_r;   // Read byte
  logic  wbs_we;
  logic  wbs_cyc;
  logic  wbs_stb;
  logic  wbs_ack;
  logic  wbs_err;

  // Lane control
  logic  start;
  logic  advance;
  lane_t lane;
  logic  lane_any;
  logic  lane_last;

  assign wbs_we = wbm_we_i;   // Direction held by master for whole access

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  wb_lane_sequencer u_sequencer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .any_i     (lane_any),
    .last_i    (lane_last),
    .wbs_ack_i (wbs_ack),
    .wbs_err_i (wbs_err),
    .start_o   (start),
    .advance_o (advance),
    .wbs_cyc_o (wbs_cyc),
    .wbs_stb_o (wbs_stb),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o)
  );

  wb_lane_counter u_counter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (start),
    .advance_i (advance),
    .sel_i     (wbm_sel_i),
    .lane_o    (lane),
    .any_o     (lane_any),
    .last_o    (lane_last)
  );

  wb_lane_datapath u_datapath (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (start),
    .advance_i (advance),
    .lane_i    (lane),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_dat_o (wbm_dat_o),
    .wbs_dat_i (wbs_dat_r),
    .wbs_adr_o (wbs_adr),
    .wbs_dat_o (wbs_dat)
  );

  wb_byte_ram u_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (wbs_cyc),
    .stb_i (wbs_stb),
    .we_i  (wbs_we),
    .adr_i (wbs_adr),
    .dat_i (wbs_dat),
    .dat_o (wbs_dat_r),
    .ack_o (wbs_ack),
    .err_o (wbs_err)
  );

endmodule

// File: verification/wb_resize_bridge_assertions.sv
// Wishbone protocol checks on both buses of the bridge, bound into the top level
module wb_resize_bridge_assertions (
  input logic clk_i,
  input logic rst_i,
  input logic wbm_cyc_i,
  input logic wbm_stb_i,
  input logic wbm_ack_i,
  input logic wbm_err_i,
  input logic wbs_cyc_i,
  input logic wbs_stb_i,
  input logic wbs_ack_i,
  input logic wbs_err_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int assert_errs = 0;   // Read by the testbench at the end

  ////////////////////////////////////////////////////////////
  // Narrow slave bus
  ////////////////////////////////////////////////////////////

  // Single cycles only, cyc follows stb
  a_slave_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      wbs_stb_i |-> wbs_cyc_i)
    else begin
      assert_errs++;
      $error("Slave stb high without slave cyc");
    end

  a_slave_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (wbs_stb_i && !wbs_ack_i && !wbs_err_i) |=> wbs_stb_i)   // Held through wait states
    else begin
      assert_errs++;
      $error("Slave stb dropped before ack or err");
    end

  ////////////////////////////////////////////////////////////
  // Wide master bus
  ////////////////////////////////////////////////////////////

  a_master_excl: assert property (@(posedge clk_i) disable iff (rst_i)
      !(wbm_ack_i && wbm_err_i))
    else begin
      assert_errs++;
      $error("Master ack and err high together");
    end

  a_master_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      wbm_ack_i |-> (wbm_cyc_i && wbm_stb_i))   // No ack outside a request
    else begin
      assert_errs++;
      $error("Master ack without cyc and stb");
    end

endmodule

bind wb_resize_bridge wb_resize_bridge_assertions u_assertions (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .wbm_cyc_i (wbm_cyc_i),
  .wbm_stb_i (wbm_stb_i),
  .wbm_ack_i (wbm_ack_o),
  .wbm_err_i (wbm_err_o),
  .wbs_cyc_i (wbs_cyc),
  .wbs_stb_i (wbs_stb),
  .wbs_ack_i (wbs_ack),
  .wbs_err_i (wbs_err)
);

// File: verification/wb_resize_bridge_tb.sv
// Table-driven testbench for the Wishbone width bridge, compiled from the file list in the root
module wb_resize_bridge_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import wb_resize_pkg::*;

  localparam int RAM_DEPTH    = 64;    // RAM default depth in bytes
  localparam int MAX_ROWS     = 96;
  localparam int RAND_ROWS    = 40;
  localparam int RESP_TIMEOUT = 200;   // Cycles allowed for ack or err
  localparam int DRIVE_DELAY  = 1;     // ns after the rising edge

  typedef struct packed {
    logic  we;
    adr_t  adr;
    sel_t  sel;
    mdat_t wdat;
    mdat_t exp_dat;   // Model bytes, zero in unselected lanes
    logic  exp_err;
    logic  chk_dat;   // Reads without error only
  } row_t;

  logic  clk_i;
  logic  rst_i;
  adr_t  wbm_adr_i;
  mdat_t wbm_dat_i;
  sel_t  wbm_sel_i;
  logic  wbm_we_i;
  logic  wbm_cyc_i;
  logic  wbm_stb_i;
  mdat_t wbm_dat_o;
  logic  wbm_ack_o;
  logic  wbm_err_o;

  row_t        rows [MAX_ROWS];
  int          row_count;
  sdat_t       model_mem [RAM_DEPTH];   // Mirror of the byte RAM
  logic [15:0] lfsr_q;
  int          data_checks, data_errs, err_checks, err_errs, timeouts;
  logic        hung;                    // Set on timeout, stops the table

  wb_resize_bridge u_dut (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;   // 8 ns period
  end

  ////////////////////////////////////////////////////////////
  // Stimulus sources
  ////////////////////////////////////////////////////////////

  // Byte pattern from the whole address, lane 3 at offset 0
  function automatic mdat_t fill_word(input int a);
    mdat_t w;
    int    k;
    w = '0;
    for (k = 0; k < LANES; k++) w = {w[MDW-SDW-1:0], sdat_t'(((a + k) * 37 + 11) & 8'hFF)};
    return w;
  endfunction

  // Fibonacci taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);      // One step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Applies the access to the model and records the expected response
  task automatic add_row(input logic we, input adr_t adr, input sel_t sel, input mdat_t wdat);
    row_t r;
    adr_t base;
    adr_t badr;
    int   lane;
    base      = adr & ~adr_t'(LANES - 1);
    r.we      = we;
    r.adr     = adr;
    r.sel     = sel;
    r.wdat    = wdat;
    r.exp_dat = '0;
    r.exp_err = 1'b0;
    for (lane = LANES - 1; lane >= 0; lane--) begin
      if (sel[lane] && !r.exp_err) begin
        badr = base + adr_t'(LANES - 1 - lane);   // Byte offset is 3 minus lane
        if (badr >= adr_t'(RAM_DEPTH)) begin
          r.exp_err = 1'b1;                       // Lower lanes aborted
        end else if (we) begin
          model_mem[int'(badr)] = wdat[lane*SDW +: SDW];
        end else begin
          r.exp_dat[lane*SDW +: SDW] = model_mem[int'(badr)];
        end
      end
    end
    r.chk_dat       = !we && !r.exp_err;
    rows[row_count] = r;
    row_count++;
  endtask

  task automatic build_table();
    int          a;
    int          k;
    logic [31:0] r_we, r_adr, r_sel, r_dat;
    for (a = 0; a < RAM_DEPTH; a += LANES) add_row(1'b1, adr_t'(a), 4'hF, fill_word(a));
    // Single lane
    add_row(1'b1, 32'h10, 4'b0100, 32'h00AB_0000);
    add_row(1'b0, 32'h10, 4'b0100, '0);
    add_row(1'b1, 32'h14, 4'b0001, 32'h0000_00CD);
    add_row(1'b0, 32'h14, 4'b0001, '0);
    // Full word, then offset 0 alone
    add_row(1'b1, 32'h20, 4'hF, 32'h1122_3344);
    add_row(1'b0, 32'h20, 4'hF, '0);
    add_row(1'b0, 32'h20, 4'b1000, '0);
    // Sparse lanes 3 and 1
    add_row(1'b1, 32'h24, 4'b1010, 32'hA1B2_C3D4);
    add_row(1'b0, 32'h24, 4'hF, '0);
    // Out of range, a leaked write would alias onto word 0
    add_row(1'b1, 32'h40, 4'hF, 32'hDEAD_BEEF);
    add_row(1'b0, 32'h80, 4'b0010, '0);
    add_row(1'b0, 32'h00, 4'hF, '0);
    // Empty select
    add_row(1'b0, 32'h08, 4'h0, '0);
    add_row(1'b1, 32'h08, 4'h0, 32'hFFFF_FFFF);
    add_row(1'b0, 32'h08, 4'hF, '0);
    add_row(1'b0, 32'h100, 4'h0, '0);   // No slave cycle, so no err
    for (k = 0; k < RAND_ROWS; k++) begin
      take_bits(1, r_we);
      take_bits(6, r_adr);                // Always inside the RAM
      take_bits(LANES, r_sel);
      take_bits(MDW, r_dat);
      add_row(r_we[0], adr_t'(r_adr), sel_t'(r_sel), mdat_t'(r_dat));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input mdat_t got, input mdat_t exp, input string what);
    data_checks++;
    if (got !== exp) begin
      data_errs++;
      $display("FAILED at %0t: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    err_checks++;
    if (got !== exp) begin
      err_errs++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int idx);
    row_t r;
    int   cycles;
    logic seen;
    r = rows[idx];
    @(posedge clk_i);
    #DRIVE_DELAY;
    wbm_adr_i = r.adr;
    wbm_dat_i = r.wdat;
    wbm_sel_i = r.sel;
    wbm_we_i  = r.we;
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;                   // Held until ack or err
    cycles    = 0;
    seen      = 1'b0;
    while (!seen && cycles < RESP_TIMEOUT) begin
      @(negedge clk_i);                 // Mid-cycle, outputs settled
      cycles++;
      seen = wbm_ack_o || wbm_err_o;
    end
    if (!seen) begin
      timeouts++;
      hung = 1'b1;
      $display("Row %0d got neither ack nor err within %0d cycles, stopping at %0t",
               idx, RESP_TIMEOUT, $time);
    end else begin
      check_err(wbm_err_o, r.exp_err, $sformatf("row %0d err", idx));
      if (r.chk_dat) check_data(wbm_dat_o, r.exp_dat, $sformatf("row %0d read word", idx));
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    wbm_cyc_i = 1'b0;                   // At least one idle cycle
    wbm_stb_i = 1'b0;
  endtask

  // Direct look at the array, confirms big-endian placement
  task automatic compare_memory();
    int    a;
    mdat_t ram_word;
    mdat_t model_word;
    for (a = 0; a < RAM_DEPTH; a += LANES) begin
      ram_word   = {u_dut.u_ram.mem[a], u_dut.u_ram.mem[a+1],
                    u_dut.u_ram.mem[a+2], u_dut.u_ram.mem[a+3]};
      model_word = {model_mem[a], model_mem[a+1], model_mem[a+2], model_mem[a+3]};
      check_data(ram_word, model_word, $sformatf("RAM word at %02h", a));
    end
  endtask

  initial begin
    int i;
    int total;
    rst_i       = 1'b1;
    wbm_adr_i   = '0;
    wbm_dat_i   = '0;
    wbm_sel_i   = '0;
    wbm_we_i    = 1'b0;
    wbm_cyc_i   = 1'b0;
    wbm_stb_i   = 1'b0;
    row_count   = 0;
    data_checks = 0;
    data_errs   = 0;
    err_checks  = 0;
    err_errs    = 0;
    timeouts    = 0;
    hung        = 1'b0;
    lfsr_q      = 16'd60;               // Seed
    build_table();
    repeat (16) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    for (i = 0; i < row_count && !hung; i++) run_row(i);
    compare_memory();
    total = data_errs + err_errs + timeouts + u_dut.u_assertions.assert_errs;
    $display("Errors: data %0d of %0d, err flag %0d of %0d, timeouts %0d, assertions %0d",
             data_errs, data_checks, err_errs, err_checks, timeouts,
             u_dut.u_assertions.assert_errs);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: wb_resize_bridge.f
src/wb_resize_pkg.sv
src/wb_lane_sequencer.sv
src/wb_lane_counter.sv
src/wb_lane_datapath.sv
src/wb_byte_ram.sv
src/wb_resize_bridge.sv
verification/wb_resize_bridge_assertions.sv
verification/wb_resize_bridge_tb.sv

// File: Bender.yml
package:
  name: wb_resize_bridge

sources:
  - src/wb_resize_pkg.sv
  - src/wb_lane_sequencer.sv
  - src/wb_lane_counter.sv
  - src/wb_lane_datapath.sv
  - src/wb_byte_ram.sv
  - src/wb_resize_bridge.sv
  - target: test
    files:
      - verification/wb_resize_bridge_assertions.sv
      - verification/wb_resize_bridge_tb.sv
